/* fetch_cache.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_stage_reg.sv
verilog/icache_array.sv
verilog/icache_controller.sv
verilog/fetch_perf_counters.sv
verilog/fetch_cache.sv
sim/fetch_mem_model.sv
sim/fetch_cache_tb.sv

/* Makefile */
# Verilator flow for the instruction fetch cache

VERILATOR ?= verilator
FILELIST  ?= fetch_cache.f
TB_TOP    ?= fetch_cache_tb
RTL_TOP   ?= fetch_cache
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --lint-only --timing

FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/fetch_cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_cache_tb;

    localparam int PERIOD        = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int SRAM_REQS     = 8;
    localparam int CONFLICT_REQS = 8;
    localparam int MIXED_REQS    = 200;
    localparam int TOTAL_REQS    = 2 + SRAM_REQS + CONFLICT_REQS + MIXED_REQS;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + RESET_CYCLES;
    localparam logic [31:0] CONTENT_KEY = 32'h5a5a_0000;

    localparam int REGION_FLASH = 0;
    localparam int REGION_SRAM  = 1;
    localparam int REGION_SDRAM = 2;
    localparam int REGION_OTHER = 3;

    logic        clock;
    logic        reset;
    logic        ifu_arvalid;
    logic [31:0] ifu_araddr;
    logic        ifu_arready;
    logic        ifu_rvalid;
    logic [31:0] ifu_rdata;
    logic        ifu_rready = 1'b1;
    logic        mem_arvalid;
    logic [31:0] mem_araddr;
    logic        mem_arready;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        mem_rready;
    logic [31:0] flash_hits;
    logic [31:0] flash_misses;
    logic [31:0] sram_hits;
    logic [31:0] sram_misses;
    logic [31:0] sdram_hits;
    logic [31:0] sdram_misses;

    // Issued requests in order, and the reads the memory should see
    logic [31:0] issued_addr  [TOTAL_REQS];
    int unsigned issued_cycle [TOTAL_REQS];
    logic [31:0] miss_addr    [TOTAL_REQS];
    int unsigned req_count  = 0;
    int unsigned rsp_count  = 0;
    int unsigned miss_count = 0;
    int unsigned mem_count  = 0;
    int unsigned cycle_count = 0;

    // Reference cache and expected counters
    logic        model_valid [16] = '{default: 1'b0};
    logic [25:0] model_tag   [16];
    int unsigned exp_hits    [4] = '{default: 0};
    int unsigned exp_misses  [4] = '{default: 0};

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_start_errors = 0;
    string test_name = "reset";
    logic  reset_check = 1'b0;
    logic  latency_check = 1'b0;
    logic  counter_check = 1'b0;
    logic  random_ready = 1'b0;

    fetch_cache fetch_cache_i (.*);

    fetch_mem_model mem_model_i (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // --------------------------------------------------
    // Reference model and monitors
    // --------------------------------------------------
    function automatic int addr_region(input logic [31:0] addr);
        if (addr[31:24] == 8'h0f)
            return REGION_SRAM;
        if (addr[31:28] == 4'h3)
            return REGION_FLASH;
        if (addr[31:28] == 4'ha || addr[31:28] == 4'hb)
            return REGION_SDRAM;
        return REGION_OTHER;
    endfunction

    // Accesses are served strictly in order, so a sequential model is exact
    function automatic logic model_lookup(input logic [31:0] addr);
        int   region;
        int   index;
        logic hit;
        region = addr_region(addr);
        index  = int'(addr[5:2]);
        hit    = (region != REGION_SRAM) && model_valid[index] && (model_tag[index] == addr[31:6]);
        if (!hit && region != REGION_SRAM) begin
            model_valid[index] = 1'b1;
            model_tag[index]   = addr[31:6];
        end
        if (hit)
            exp_hits[region]++;
        else
            exp_misses[region]++;
        return hit;
    endfunction

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (!reset && ifu_arvalid && ifu_arready) begin
            issued_addr[req_count]  <= ifu_araddr;
            issued_cycle[req_count] <= cycle_count;
            req_count <= req_count + 1;
            if (!model_lookup(ifu_araddr)) begin
                miss_addr[miss_count] <= ifu_araddr;
                miss_count <= miss_count + 1;
            end
        end
        if (!reset && ifu_rvalid && ifu_rready)
            rsp_count <= rsp_count + 1;
        if (!reset && mem_arvalid && mem_arready)
            mem_count <= mem_count + 1;
    end

    always @(posedge clock) begin
        if (random_ready)
            ifu_rready <= ($urandom_range(1, 0) == 1);
        else
            ifu_rready <= 1'b1;
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("error %s: %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure in %s: %s", test_name, what);
    endtask

    // Bits are ifu_rvalid, mem_arvalid, mem_rready, ifu_arready
    assert property (@(posedge clock) reset_check |->
        {ifu_rvalid, mem_arvalid, mem_rready, ifu_arready} == 4'b0001)
        else report_mismatch("handshake state", 32'h1,
            32'($sampled({ifu_rvalid, mem_arvalid, mem_rready, ifu_arready})));
    assert property (@(posedge clock) reset_check |->
        (flash_hits | flash_misses | sram_hits | sram_misses | sdram_hits | sdram_misses) == 0)
        else report_failure("a counter is not zero after reset");

    assert property (@(posedge clock) disable iff (reset)
        (ifu_rvalid && ifu_rready) |-> (rsp_count < req_count))
        else report_failure("response returned with no request outstanding");
    assert property (@(posedge clock) disable iff (reset)
        (ifu_rvalid && ifu_rready && rsp_count < req_count) |->
            (ifu_rdata == (issued_addr[rsp_count] ^ CONTENT_KEY)))
        else report_mismatch("ifu_rdata", $sampled(issued_addr[rsp_count]) ^ CONTENT_KEY,
            $sampled(ifu_rdata));
    assert property (@(posedge clock) disable iff (reset)
        (ifu_rvalid && !ifu_rready) |=> (ifu_rvalid && $stable(ifu_rdata)))
        else report_failure("ifu_rvalid or ifu_rdata changed before the transfer");

    assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && mem_arready) |-> (mem_count < miss_count))
        else report_failure("memory read issued for an access that should hit");
    assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && mem_arready && mem_count < miss_count) |->
            (mem_araddr == miss_addr[mem_count]))
        else report_mismatch("mem_araddr", $sampled(miss_addr[mem_count]), $sampled(mem_araddr));
    assert property (@(posedge clock) disable iff (reset)
        (mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_araddr)))
        else report_failure("mem_arvalid or mem_araddr changed before the transfer");

    assert property (@(posedge clock) disable iff (reset)
        (latency_check && ifu_rvalid && ifu_rready) |->
            (cycle_count - issued_cycle[rsp_count] == 2))
        else report_mismatch("hit latency in edges", 32'd2,
            $sampled(cycle_count - issued_cycle[rsp_count]));

    assert property (@(posedge clock) sram_hits == 0)
        else report_mismatch("sram_hits", 32'd0, $sampled(sram_hits));

    // Counters against the reference once the pipeline is empty
    assert property (@(posedge clock) counter_check |-> flash_hits == exp_hits[REGION_FLASH])
        else report_mismatch("flash_hits", exp_hits[REGION_FLASH], flash_hits);
    assert property (@(posedge clock) counter_check |-> flash_misses == exp_misses[REGION_FLASH])
        else report_mismatch("flash_misses", exp_misses[REGION_FLASH], flash_misses);
    assert property (@(posedge clock) counter_check |-> sram_misses == exp_misses[REGION_SRAM])
        else report_mismatch("sram_misses", exp_misses[REGION_SRAM], sram_misses);
    assert property (@(posedge clock) counter_check |-> sdram_hits == exp_hits[REGION_SDRAM])
        else report_mismatch("sdram_hits", exp_hits[REGION_SDRAM], sdram_hits);
    assert property (@(posedge clock) counter_check |-> sdram_misses == exp_misses[REGION_SDRAM])
        else report_mismatch("sdram_misses", exp_misses[REGION_SDRAM], sdram_misses);
    assert property (@(posedge clock) counter_check |-> mem_count == miss_count)
        else report_mismatch("memory read count", miss_count, mem_count);

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic send_request(input logic [31:0] addr);
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= addr;
        @(posedge clock);
        while (!ifu_arready)
            @(posedge clock);
        ifu_arvalid <= 1'b0;
    endtask

    task automatic wait_idle();
        // Request count of the last transfer settles one edge later
        @(posedge clock);
        while (rsp_count != req_count)
            @(posedge clock);
        repeat (2) @(posedge clock);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        counter_check <= 1'b1;
        @(posedge clock);
        counter_check <= 1'b0;
        @(posedge clock);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // Few tags per index so that hits and conflicts both show up
    function automatic logic [31:0] random_addr();
        logic [31:0] base;
        case ($urandom_range(3, 0))
            0: base = 32'h3000_0000;
            1: base = 32'h0f00_0000;
            2: base = 32'ha000_0000;
            default: base = 32'h7000_0000;
        endcase
        return base | ($urandom_range(1, 0) << 6) | ($urandom_range(15, 0) << 2);
    endfunction

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        ifu_arvalid = 1'b0;
        ifu_araddr  = '0;
        reset       = 1'b1;
        void'($urandom(32'h4930));
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        start_test("reset_state");
        @(posedge clock);
        reset_check <= 1'b1;
        @(posedge clock);
        reset_check <= 1'b0;
        finish_test();

        start_test("cold_miss_then_hit");
        send_request(32'h3000_0040);
        wait_idle();
        latency_check <= 1'b1;
        send_request(32'h3000_0040);
        wait_idle();
        latency_check <= 1'b0;
        finish_test();

        start_test("sram_bypass");
        for (int i = 0; i < SRAM_REQS; i++)
            send_request(32'h0f00_0100 + 32'(4 * (i % 3)));
        wait_idle();
        finish_test();

        start_test("index_conflict");
        for (int i = 0; i < CONFLICT_REQS; i++)
            send_request((i % 2 == 0) ? 32'ha000_0010 : 32'hb000_0010);
        wait_idle();
        finish_test();

        start_test("back_pressure_mixed");
        random_ready <= 1'b1;
        for (int i = 0; i < MIXED_REQS; i++) begin
            send_request(random_addr());
            repeat ($urandom_range(2, 0)) @(posedge clock);
        end
        wait_idle();
        random_ready <= 1'b0;
        finish_test();

        start_test("counters");
        wait_idle();
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired in %s, %0d of %0d responses seen",
                 test_name, rsp_count, req_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/fetch_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

// Instruction memory with one read in flight, a random address ready and a random response delay
module fetch_mem_model (
    input  wire logic                         clock,
    input  wire logic                         reset,

    input  wire logic                         mem_arvalid,
    input  wire logic [`FETCH_ADDR_WIDTH-1:0] mem_araddr,
    output logic                              mem_arready,
    output logic                              mem_rvalid,
    output logic      [`FETCH_DATA_WIDTH-1:0] mem_rdata,
    input  wire logic                         mem_rready
);

    logic                         busy;
    int unsigned                  delay;
    logic [`FETCH_ADDR_WIDTH-1:0] addr;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_arready <= 1'b0;
            mem_rvalid  <= 1'b0;
            mem_rdata   <= '0;
            busy        <= 1'b0;
            delay       <= 0;
            addr        <= '0;
        end else if (!busy) begin
            if (mem_arvalid && mem_arready) begin
                busy        <= 1'b1;
                mem_arready <= 1'b0;
                addr        <= mem_araddr;
                delay       <= $urandom_range(6, 1);
            end else begin
                // Address ready comes and goes while idle
                mem_arready <= ($urandom_range(1, 0) == 1);
            end
        end else if (mem_rvalid) begin
            // Word held until the cache takes it
            if (mem_rready) begin
                mem_rvalid  <= 1'b0;
                busy        <= 1'b0;
                mem_arready <= 1'b1;
            end
        end else if (delay > 1) begin
            delay <= delay - 1;
        end else begin
            mem_rvalid <= 1'b1;
            mem_rdata  <= addr ^ 32'h5a5a_0000;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_cache (
    input  wire logic                          clock,
    input  wire logic                          reset,

    // Fetch unit read channel
    input  wire logic                          ifu_arvalid,
    input  wire logic [`FETCH_ADDR_WIDTH-1:0]  ifu_araddr,
    output logic                               ifu_arready,
    output logic                               ifu_rvalid,
    output logic      [`FETCH_DATA_WIDTH-1:0]  ifu_rdata,
    input  wire logic                          ifu_rready,

    // Memory read channel
    output logic                               mem_arvalid,
    output logic      [`FETCH_ADDR_WIDTH-1:0]  mem_araddr,
    input  wire logic                          mem_arready,
    input  wire logic                          mem_rvalid,
    input  wire logic [`FETCH_DATA_WIDTH-1:0]  mem_rdata,
    output logic                               mem_rready,

    // Performance counters
    output logic      [`FETCH_COUNT_WIDTH-1:0] flash_hits,
    output logic      [`FETCH_COUNT_WIDTH-1:0] flash_misses,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sram_hits,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sram_misses,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sdram_hits,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sdram_misses
);

    fetch_pkg::fetch_req_t          ifu_req;
    fetch_pkg::fetch_req_t          req;
    logic                           req_valid;
    logic                           req_ready;

    fetch_pkg::fetch_rsp_t          rsp;
    fetch_pkg::fetch_rsp_t          ifu_rsp;
    logic                           rsp_valid;
    logic                           rsp_ready;

    logic [`FETCH_ADDR_WIDTH-1:0]   lookup_addr;
    logic                           lookup_hit;
    logic [`FETCH_DATA_WIDTH-1:0]   lookup_data;
    logic                           fill_valid;
    logic [`FETCH_ADDR_WIDTH-1:0]   fill_addr;
    logic [`FETCH_DATA_WIDTH-1:0]   fill_data;

    logic                           access_valid;
    logic                           access_hit;
    fetch_pkg::region_t             access_region;

    assign ifu_req.addr = ifu_araddr;
    assign ifu_rdata    = ifu_rsp.data;

    // --------------------------------------------------
    // Request stage
    // --------------------------------------------------
    fetch_stage_reg #(.payload_t(fetch_pkg::fetch_req_t)) req_stage_i (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (ifu_arvalid),
        .in_payload (ifu_req),
        .in_ready   (ifu_arready),
        .out_valid  (req_valid),
        .out_payload(req),
        .out_ready  (req_ready)
    );

    // --------------------------------------------------
    // Lookup and control
    // --------------------------------------------------
    icache_array icache_array_i (
        .clock      (clock),
        .reset      (reset),
        .lookup_addr(lookup_addr),
        .lookup_hit (lookup_hit),
        .lookup_data(lookup_data),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data)
    );

    icache_controller icache_controller_i (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .lookup_addr  (lookup_addr),
        .lookup_hit   (lookup_hit),
        .lookup_data  (lookup_data),
        .fill_valid   (fill_valid),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_ready    (rsp_ready),
        .mem_arvalid  (mem_arvalid),
        .mem_araddr   (mem_araddr),
        .mem_arready  (mem_arready),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .mem_rready   (mem_rready),
        .access_valid (access_valid),
        .access_hit   (access_hit),
        .access_region(access_region)
    );

    // --------------------------------------------------
    // Response stage
    // --------------------------------------------------
    fetch_stage_reg #(.payload_t(fetch_pkg::fetch_rsp_t)) rsp_stage_i (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (rsp_valid),
        .in_payload (rsp),
        .in_ready   (rsp_ready),
        .out_valid  (ifu_rvalid),
        .out_payload(ifu_rsp),
        .out_ready  (ifu_rready)
    );

    fetch_perf_counters fetch_perf_counters_i (
        .clock        (clock),
        .reset        (reset),
        .access_valid (access_valid),
        .access_hit   (access_hit),
        .access_region(access_region),
        .flash_hits   (flash_hits),
        .flash_misses (flash_misses),
        .sram_hits    (sram_hits),
        .sram_misses  (sram_misses),
        .sdram_hits   (sdram_hits),
        .sdram_misses (sdram_misses)
    );

endmodule

`default_nettype wire

/* verilog/fetch_perf_counters.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_perf_counters (
    input  wire logic                          clock,
    input  wire logic                          reset,

    input  wire logic                          access_valid,
    input  wire logic                          access_hit,
    input  fetch_pkg::region_t                 access_region,

    output logic      [`FETCH_COUNT_WIDTH-1:0] flash_hits,
    output logic      [`FETCH_COUNT_WIDTH-1:0] flash_misses,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sram_hits,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sram_misses,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sdram_hits,
    output logic      [`FETCH_COUNT_WIDTH-1:0] sdram_misses
);

    logic is_flash;
    logic is_sram;
    logic is_sdram;

    assign is_flash = access_valid && (access_region == fetch_pkg::region_flash);
    assign is_sram  = access_valid && (access_region == fetch_pkg::region_sram);
    assign is_sdram = access_valid && (access_region == fetch_pkg::region_sdram);

    // --------------------------------------------------
    // Counters, region_other is never counted
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flash_hits   <= '0;
            flash_misses <= '0;
            sram_hits    <= '0;
            sram_misses  <= '0;
            sdram_hits   <= '0;
            sdram_misses <= '0;
        end else begin
            if (is_flash && access_hit)
                flash_hits <= flash_hits + 1'b1;
            if (is_flash && !access_hit)
                flash_misses <= flash_misses + 1'b1;
            // Sram is always bypassed, so no hit ever arrives here
            if (is_sram && access_hit)
                sram_hits <= sram_hits + 1'b1;
            if (is_sram && !access_hit)
                sram_misses <= sram_misses + 1'b1;
            if (is_sdram && access_hit)
                sdram_hits <= sdram_hits + 1'b1;
            if (is_sdram && !access_hit)
                sdram_misses <= sdram_misses + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module icache_controller (
    input  wire logic                         clock,
    input  wire logic                         reset,

    // From the request stage
    input  wire logic                         req_valid,
    input  fetch_pkg::fetch_req_t             req,
    output logic                              req_ready,

    // Array lookup and fill
    output logic      [`FETCH_ADDR_WIDTH-1:0] lookup_addr,
    input  wire logic                         lookup_hit,
    input  wire logic [`FETCH_DATA_WIDTH-1:0] lookup_data,
    output logic                              fill_valid,
    output logic      [`FETCH_ADDR_WIDTH-1:0] fill_addr,
    output logic      [`FETCH_DATA_WIDTH-1:0] fill_data,

    // To the response stage
    output logic                              rsp_valid,
    output fetch_pkg::fetch_rsp_t             rsp,
    input  wire logic                         rsp_ready,

    // Memory read channel
    output logic                              mem_arvalid,
    output logic      [`FETCH_ADDR_WIDTH-1:0] mem_araddr,
    input  wire logic                         mem_arready,
    input  wire logic                         mem_rvalid,
    input  wire logic [`FETCH_DATA_WIDTH-1:0] mem_rdata,
    output logic                              mem_rready,

    // Access report for the counters
    output logic                              access_valid,
    output logic                              access_hit,
    output fetch_pkg::region_t                access_region
);

    typedef enum logic [1:0] {
        st_lookup,
        st_addr,
        st_data
    } state_t;

    state_t             state;
    state_t             state_next;
    fetch_pkg::region_t region;
    logic               cacheable;
    logic               hit_now;
    logic               mem_r_fire;

    // --------------------------------------------------
    // Classification
    // --------------------------------------------------
    // The request stays at the stage output until consumed, so no address copy
    assign region    = fetch_pkg::region_of(req.addr);
    assign cacheable = (region != fetch_pkg::region_sram);

    assign lookup_addr = req.addr;
    assign hit_now     = (state == st_lookup) && req_valid && cacheable && lookup_hit;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_lookup: begin
                // Miss or bypass goes out to memory
                if (req_valid && !(cacheable && lookup_hit))
                    state_next = st_addr;
            end
            st_addr: begin
                if (mem_arready)
                    state_next = st_data;
            end
            st_data: begin
                if (mem_r_fire)
                    state_next = st_lookup;
            end
            default: state_next = st_lookup;
        endcase
    end

    // --------------------------------------------------
    // Memory side
    // --------------------------------------------------
    assign mem_arvalid = (state == st_addr);
    assign mem_araddr  = req.addr;
    // Only take data when the response stage can take it too
    assign mem_rready  = (state == st_data) && rsp_ready;
    assign mem_r_fire  = mem_rvalid && mem_rready;

    // Fill only regions that are cached
    assign fill_valid = mem_r_fire && cacheable;
    assign fill_addr  = req.addr;
    assign fill_data  = mem_rdata;

    // --------------------------------------------------
    // Response and request handshake
    // --------------------------------------------------
    assign rsp_valid = hit_now || ((state == st_data) && mem_rvalid);
    assign rsp.data  = (state == st_data) ? mem_rdata : lookup_data;
    assign req_ready = rsp_valid && rsp_ready;

    // One pulse per response handed over
    assign access_valid  = rsp_valid && rsp_ready;
    assign access_hit    = (state == st_lookup);
    assign access_region = region;

endmodule

`default_nettype wire

/* verilog/icache_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module icache_array (
    input  wire logic                         clock,
    input  wire logic                         reset,

    // Lookup port, combinational
    input  wire logic [`FETCH_ADDR_WIDTH-1:0] lookup_addr,
    output logic                              lookup_hit,
    output logic      [`FETCH_DATA_WIDTH-1:0] lookup_data,

    // Fill port, written on the clock edge
    input  wire logic                         fill_valid,
    input  wire logic [`FETCH_ADDR_WIDTH-1:0] fill_addr,
    input  wire logic [`FETCH_DATA_WIDTH-1:0] fill_data
);

    localparam int LINES = 1 << `FETCH_INDEX_WIDTH;
    localparam int INDEX_LSB = `FETCH_OFFSET_WIDTH;
    localparam int TAG_LSB = `FETCH_OFFSET_WIDTH + `FETCH_INDEX_WIDTH;

    logic [LINES-1:0]              valid_bits;
    logic [`FETCH_TAG_WIDTH-1:0]   tag_mem  [LINES];
    logic [`FETCH_DATA_WIDTH-1:0]  data_mem [LINES];

    logic [`FETCH_INDEX_WIDTH-1:0] lookup_index;
    logic [`FETCH_TAG_WIDTH-1:0]   lookup_tag;
    logic [`FETCH_INDEX_WIDTH-1:0] fill_index;
    logic [`FETCH_TAG_WIDTH-1:0]   fill_tag;

    // --------------------------------------------------
    // Address split
    // --------------------------------------------------
    assign lookup_index = lookup_addr[INDEX_LSB +: `FETCH_INDEX_WIDTH];
    assign lookup_tag   = lookup_addr[`FETCH_ADDR_WIDTH-1:TAG_LSB];
    assign fill_index   = fill_addr[INDEX_LSB +: `FETCH_INDEX_WIDTH];
    assign fill_tag     = fill_addr[`FETCH_ADDR_WIDTH-1:TAG_LSB];

    // --------------------------------------------------
    // Lookup
    // --------------------------------------------------
    assign lookup_hit  = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign lookup_data = data_mem[lookup_index];

    // --------------------------------------------------
    // Fill
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_valid) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

// One-entry valid/ready register, ready passes through from the output side
module fetch_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic clock,
    input  wire logic reset,

    input  wire logic in_valid,
    input  payload_t  in_payload,
    output logic      in_ready,

    output logic      out_valid,
    output payload_t  out_payload,
    input  wire logic out_ready
);

    logic in_fire;

    // Empty, or the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clock) begin
        if (in_fire) begin
            out_payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        region_flash,
        region_sram,
        region_sdram,
        region_other
    } region_t;

    // Request stage payload
    typedef struct packed {
        logic [`FETCH_ADDR_WIDTH-1:0] addr;
    } fetch_req_t;

    // Response stage payload
    typedef struct packed {
        logic [`FETCH_DATA_WIDTH-1:0] data;
    } fetch_rsp_t;

    // Sram is checked first, its top nibble overlaps nothing else
    function automatic region_t region_of(input logic [`FETCH_ADDR_WIDTH-1:0] addr);
        if (addr[`FETCH_ADDR_WIDTH-1 -: 8] == `FETCH_SRAM_BYTE)
            return region_sram;
        if (addr[`FETCH_ADDR_WIDTH-1 -: 4] == `FETCH_FLASH_NIBBLE)
            return region_flash;
        if (addr[`FETCH_ADDR_WIDTH-1 -: 4] == `FETCH_SDRAM_NIBBLE_LO ||
            addr[`FETCH_ADDR_WIDTH-1 -: 4] == `FETCH_SDRAM_NIBBLE_HI)
            return region_sdram;
        return region_other;
    endfunction

endpackage

`default_nettype wire

/* verilog/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// --------------------------------------------------
// Address and data geometry
// --------------------------------------------------
`define FETCH_ADDR_WIDTH   32
`define FETCH_DATA_WIDTH   32
`define FETCH_OFFSET_WIDTH 2
// 16 lines of one word each
`define FETCH_INDEX_WIDTH  4
`define FETCH_TAG_WIDTH    (`FETCH_ADDR_WIDTH - `FETCH_INDEX_WIDTH - `FETCH_OFFSET_WIDTH)
`define FETCH_COUNT_WIDTH  32

// --------------------------------------------------
// Region decode values, matched against top address bits
// --------------------------------------------------
`define FETCH_FLASH_NIBBLE    4'h3
`define FETCH_SRAM_BYTE       8'h0f
`define FETCH_SDRAM_NIBBLE_LO 4'ha
`define FETCH_SDRAM_NIBBLE_HI 4'hb

`endif
